/* dp_pkg.sv */
package dp_pkg;

    // Width of one datapath word
    localparam int unsigned DATA_W = 16;

    // Length of the mix stage chain
    localparam int unsigned NUM_STAGES = 4;

    // Rotate-left amount, same for every stage
    localparam int unsigned ROT_AMT = 3;

    // One additive key per stage, index is the stage position
    localparam logic [DATA_W-1:0] STAGE_KEY [NUM_STAGES] = '{
        16'h3a5c,
        16'h91e7,
        16'h0f2d,
        16'hc4b8
    };

endpackage

/* filelist.f */
+incdir+.
dp_pkg.sv
tdmr_pkg.sv
time_dmr_start.sv
mix_stage.sv
time_dmr_end.sv
tdmr_pipeline_top.sv
tb_clkgen.sv
tdmr_pipeline_chk.sv
tdmr_pipeline_tb.sv

/* mix_stage.sv */
`timescale 1ns/1ps

module mix_stage #(
    parameter int unsigned STAGE_IDX = 0
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         inject_i,
    input  logic [dp_pkg::DATA_W-1:0]    data_i,
    input  logic [tdmr_pkg::ID_SIZE-1:0] id_i,
    input  logic                         valid_i,
    output logic                         ready_o,
    output logic [dp_pkg::DATA_W-1:0]    data_o,
    output logic [tdmr_pkg::ID_SIZE-1:0] id_o,
    output logic                         valid_o,
    input  logic                         ready_i
);
    import tdmr_pkg::*;
    import dp_pkg::*;

    logic [DATA_W-1:0]  rot_data;
    logic [DATA_W-1:0]  mix_data;
    logic [DATA_W-1:0]  data_q;
    logic [ID_SIZE-1:0] id_q;
    logic               valid_q;
    logic               accept;

    // Rotate left, then add the stage key modulo 2^DATA_W
    assign rot_data = {data_i[DATA_W-1-ROT_AMT:0], data_i[DATA_W-1:DATA_W-ROT_AMT]};
    // Injected fault flips bit 0 of the result
    assign mix_data = (rot_data + STAGE_KEY[STAGE_IDX]) ^ {{(DATA_W-1){1'b0}}, inject_i};

    // Room when empty or when the held word leaves this cycle
    assign ready_o = !valid_q || ready_i;
    assign accept  = valid_i && ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            data_q <= mix_data;
            id_q   <= id_i;
        end
    end

    assign data_o  = data_q;
    assign id_o    = id_q;
    assign valid_o = valid_q;

endmodule

/* tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk_o
);
    // Free running clock, first rising edge after half a period
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

endmodule

/* tdmr_pipeline_chk.sv */
`timescale 1ns/1ps

module tdmr_pipeline_chk (
    input logic                         clk_i,
    input logic                         rst_ni,
    input logic [dp_pkg::DATA_W-1:0]    data_i,
    input logic [tdmr_pkg::ID_SIZE-1:0] id_i,
    input logic                         valid_i,
    input logic                         fault_i,
    input logic                         ready_i
);
    // Count of failed properties, the testbench watches it
    int unsigned fail_cnt = 0;

    // A stalled result keeps its data, ID and fault flag until taken
    hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_i && !ready_i |=> valid_i && $stable(data_i) && $stable(id_i) && $stable(fault_i))
    else begin
        $error("Output result changed while stalled");
        fail_cnt++;
    end

    // Nothing leaves the pipeline during reset
    quiet_in_reset: assert property (@(posedge clk_i)
        !rst_ni |-> !valid_i && !fault_i)
    else begin
        $error("Output valid or fault high during reset");
        fail_cnt++;
    end

    // Fault flag belongs to a valid result only
    fault_with_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fault_i |-> valid_i)
    else begin
        $error("Fault flag high without a valid result");
        fail_cnt++;
    end

endmodule

/* tdmr_pipeline_tb.sv */
`timescale 1ns/1ps

module tdmr_pipeline_tb;
    import dp_pkg::*;
    import tdmr_pkg::*;

    localparam int unsigned SEED            = 60774;
    localparam int unsigned N_PLAIN         = 24;
    localparam int unsigned N_STALL         = 24;
    localparam int unsigned N_INJECT        = 2;
    localparam int unsigned N_BYPASS        = 16;
    localparam int unsigned N_WORDS         = N_PLAIN + N_STALL + N_INJECT + N_BYPASS;
    localparam int unsigned WATCHDOG_CYCLES = 40 * N_WORDS + 200;

    logic               clk_i;
    logic               rst_ni;
    logic               enable_i;
    logic               inject_i;
    logic [DATA_W-1:0]  in_data_i;
    logic               in_valid_i;
    logic               in_ready_o;
    logic [DATA_W-1:0]  out_data_o;
    logic [ID_SIZE-1:0] out_id_o;
    logic               out_valid_o;
    logic               out_fault_o;
    logic               out_ready_i;
    logic               stall_en;
    logic               seen_out;
    logic [ID_SIZE-1:0] last_id;
    logic [DATA_W-1:0]  exp_data_q [$];
    logic               exp_fault_q [$];
    int unsigned        n_in;
    int unsigned        n_out;

    tb_clkgen #(.PERIOD_NS(4.0)) u_clkgen (.clk_o(clk_i));

    tdmr_pipeline_top dut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .enable_i    (enable_i),
        .inject_i    (inject_i),
        .in_data_i   (in_data_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_data_o  (out_data_o),
        .out_id_o    (out_id_o),
        .out_valid_o (out_valid_o),
        .out_fault_o (out_fault_o),
        .out_ready_i (out_ready_i)
    );

    bind tdmr_pipeline_top tdmr_pipeline_chk u_chk (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .data_i  (out_data_o),
        .id_i    (out_id_o),
        .valid_i (out_valid_o),
        .fault_i (out_fault_o),
        .ready_i (out_ready_i)
    );

    // Rotate left and add the key once per stage
    function automatic logic [DATA_W-1:0] expected_result(input logic [DATA_W-1:0] x);
        logic [DATA_W-1:0] v;
        v = x;
        for (int k = 0; k < NUM_STAGES; k++) begin
            v = ((v << ROT_AMT) | (v >> (DATA_W - ROT_AMT))) + STAGE_KEY[k];
        end
        return v;
    endfunction

    task automatic stop_run();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        $display("MISMATCH time %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic give_up(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_output();
        logic [DATA_W-1:0]  exp_data;
        logic               exp_fault;
        logic [ID_SIZE-1:0] exp_id;
        exp_id = ID_SIZE'(last_id + 1'b1);
        if (exp_data_q.size() == 0) begin
            give_up("an output word appeared with no input word pending");
        end else begin
            exp_data  = exp_data_q.pop_front();
            exp_fault = exp_fault_q.pop_front();
            assert (out_data_o == exp_data)
                else report_mismatch($sformatf("data %h, expected %h", out_data_o, exp_data));
            assert (out_fault_o == exp_fault)
                else report_mismatch($sformatf("fault %b, expected %b", out_fault_o, exp_fault));
            assert (!seen_out || out_id_o == exp_id)
                else report_mismatch($sformatf("id %0d, expected %0d", out_id_o, exp_id));
            last_id  = out_id_o;
            seen_out = 1'b1;
            n_out++;
        end
    endtask

    // Both handshakes are sampled at the falling edge where they are stable
    // A transfer seen here commits on the next rising edge
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (in_valid_i && in_ready_o) begin
                exp_data_q.push_back(expected_result(in_data_i));
                exp_fault_q.push_back(enable_i && inject_i);
                n_in++;
            end
            if (out_valid_o && out_ready_i) begin
                check_output();
            end
        end
    end

    // Random back-pressure on the output
    task automatic drive_back_pressure();
        forever begin
            @(posedge clk_i);
            #1;
            out_ready_i = stall_en ? (($urandom % 3) != 0) : 1'b1;
        end
    endtask

    task automatic send_word(input logic [DATA_W-1:0] value, input logic inj);
        logic taken;
        taken      = 1'b0;
        in_data_i  = value;
        in_valid_i = 1'b1;
        inject_i   = inj;
        while (!taken) begin
            @(negedge clk_i);
            taken = in_ready_o;
            @(posedge clk_i);
            #1;
            inject_i = 1'b0;
        end
        in_valid_i = 1'b0;
    endtask

    task automatic send_burst(input int unsigned count);
        for (int unsigned i = 0; i < count; i++) begin
            repeat ($urandom % 3) begin
                @(posedge clk_i);
                #1;
            end
            send_word(DATA_W'($urandom), 1'b0);
        end
    endtask

    // Wait until every accepted word has left the pipeline
    task automatic drain();
        while (n_out != n_in) begin
            @(posedge clk_i);
        end
        repeat (2) @(posedge clk_i);
        #1;
    endtask

    initial begin
        void'($urandom(SEED));
        rst_ni      = 1'b1;
        enable_i    = 1'b1;
        inject_i    = 1'b0;
        in_data_i   = '0;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b1;
        stall_en    = 1'b0;
        seen_out    = 1'b0;
        last_id     = '0;
        n_in        = 0;
        n_out       = 0;
        fork
            drive_back_pressure();
        join_none
        #1 rst_ni = 1'b0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        // Replicated words with a free flowing output
        send_burst(N_PLAIN);
        drain();
        stall_en = 1'b1;
        send_burst(N_STALL);
        drain();
        stall_en = 1'b0;
        // First copy corrupted in stage 0 while the pipe is empty
        for (int unsigned i = 0; i < N_INJECT; i++) begin
            send_word(DATA_W'($urandom), 1'b1);
            drain();
        end
        // Single pass mode is entered on an empty pipeline
        enable_i = 1'b0;
        stall_en = 1'b1;
        send_burst(N_BYPASS);
        drain();
        stall_en = 1'b0;
        repeat (10) @(posedge clk_i);
        if (dut.u_chk.fail_cnt == 0 && exp_data_q.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            give_up("a protocol assertion failed or words were left in the pipeline");
        end
    end

    initial begin
        wait (dut.u_chk.fail_cnt != 0);
        give_up("a protocol assertion on the DUT outputs failed");
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        give_up("timeout, the pipeline did not deliver all words in time");
    end

endmodule

/* tdmr_pipeline_top.sv */
`timescale 1ns/1ps

module tdmr_pipeline_top (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         enable_i,
    input  logic                         inject_i,
    input  logic [dp_pkg::DATA_W-1:0]    in_data_i,
    input  logic                         in_valid_i,
    output logic                         in_ready_o,
    output logic [dp_pkg::DATA_W-1:0]    out_data_o,
    output logic [tdmr_pkg::ID_SIZE-1:0] out_id_o,
    output logic                         out_valid_o,
    output logic                         out_fault_o,
    input  logic                         out_ready_i
);
    import tdmr_pkg::*;
    import dp_pkg::*;

    // Link k feeds stage k, the last link feeds the comparator
    logic [DATA_W-1:0]  lnk_data  [NUM_STAGES+1];
    logic [ID_SIZE-1:0] lnk_id    [NUM_STAGES+1];
    logic               lnk_valid [NUM_STAGES+1];
    logic               lnk_ready [NUM_STAGES+1];

    time_dmr_start u_start (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .enable_i (enable_i),
        .data_i   (in_data_i),
        .valid_i  (in_valid_i),
        .ready_o  (in_ready_o),
        .data_o   (lnk_data[0]),
        .id_o     (lnk_id[0]),
        .valid_o  (lnk_valid[0]),
        .ready_i  (lnk_ready[0])
    );

    for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
        // Fault injection reaches the first stage only
        mix_stage #(
            .STAGE_IDX (k)
        ) u_stage (
            .clk_i    (clk_i),
            .rst_ni   (rst_ni),
            .inject_i ((k == 0) ? inject_i : 1'b0),
            .data_i   (lnk_data[k]),
            .id_i     (lnk_id[k]),
            .valid_i  (lnk_valid[k]),
            .ready_o  (lnk_ready[k]),
            .data_o   (lnk_data[k+1]),
            .id_o     (lnk_id[k+1]),
            .valid_o  (lnk_valid[k+1]),
            .ready_i  (lnk_ready[k+1])
        );
    end

    time_dmr_end u_end (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .enable_i (enable_i),
        .data_i   (lnk_data[NUM_STAGES]),
        .id_i     (lnk_id[NUM_STAGES]),
        .valid_i  (lnk_valid[NUM_STAGES]),
        .ready_o  (lnk_ready[NUM_STAGES]),
        .data_o   (out_data_o),
        .id_o     (out_id_o),
        .valid_o  (out_valid_o),
        .fault_o  (out_fault_o),
        .ready_i  (out_ready_i)
    );

endmodule

/* tdmr_pkg.sv */
package tdmr_pkg;

    // Width of the sequence ID attached to every copy
    // Two bits are plenty for an in-order datapath
    localparam int unsigned ID_SIZE = 2;

    // Replicator states
    // STORE_AND_SEND  idle, first copy goes out straight from the input
    // SEND            first copy is held in the store until downstream takes it
    // REPLICATE       second copy goes out from the store
    typedef enum logic [1:0] {
        STORE_AND_SEND = 2'd0,
        SEND           = 2'd1,
        REPLICATE      = 2'd2
    } tdmr_state_e;

endpackage

/* time_dmr_end.sv */
`timescale 1ns/1ps

module time_dmr_end (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         enable_i,
    input  logic [dp_pkg::DATA_W-1:0]    data_i,
    input  logic [tdmr_pkg::ID_SIZE-1:0] id_i,
    input  logic                         valid_i,
    output logic                         ready_o,
    output logic [dp_pkg::DATA_W-1:0]    data_o,
    output logic [tdmr_pkg::ID_SIZE-1:0] id_o,
    output logic                         valid_o,
    output logic                         fault_o,
    input  logic                         ready_i
);
    import tdmr_pkg::*;
    import dp_pkg::*;

    // First copy of the pair
    logic [DATA_W-1:0]  first_data_q;
    logic [ID_SIZE-1:0] first_id_q;
    logic               first_vld_q;

    // Result register
    logic [DATA_W-1:0]  out_data_q;
    logic [ID_SIZE-1:0] out_id_q;
    logic               out_vld_q;
    logic               out_fault_q;

    logic               is_second;
    logic               emit;
    logic               out_free;
    logic               accept;
    logic               load_first;
    logic               load_out;

    // A copy whose ID matches the stored one completes the pair
    // Otherwise it replaces the stored copy and pairing starts again
    assign is_second = first_vld_q && (id_i == first_id_q);
    // Without replication every word goes straight to the result register
    assign emit      = !enable_i || is_second;
    assign out_free  = !out_vld_q || ready_i;

    // A first copy is always taken, a result only when the output has room
    assign ready_o    = !emit || out_free;
    assign accept     = valid_i && ready_o;
    assign load_first = accept && !emit;
    assign load_out   = accept && emit;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            first_vld_q <= 1'b0;
            out_vld_q   <= 1'b0;
            out_fault_q <= 1'b0;
        end else begin
            if (load_first) begin
                first_vld_q <= 1'b1;
            end else if (load_out) begin
                first_vld_q <= 1'b0;
            end
            if (load_out) begin
                out_vld_q   <= 1'b1;
                out_fault_q <= enable_i && (data_i != first_data_q);
            end else if (ready_i) begin
                // Fault drops together with valid once the result is taken
                out_vld_q   <= 1'b0;
                out_fault_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_first) begin
            first_data_q <= data_i;
            first_id_q   <= id_i;
        end
        if (load_out) begin
            out_data_q <= data_i;
            out_id_q   <= id_i;
        end
    end

    assign data_o  = out_data_q;
    assign id_o    = out_id_q;
    assign valid_o = out_vld_q;
    assign fault_o = out_fault_q;

endmodule

/* time_dmr_start.sv */
`timescale 1ns/1ps
`include "voters.svh"

module time_dmr_start (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         enable_i,
    input  logic [dp_pkg::DATA_W-1:0]    data_i,
    input  logic                         valid_i,
    output logic                         ready_o,
    output logic [dp_pkg::DATA_W-1:0]    data_o,
    output logic [tdmr_pkg::ID_SIZE-1:0] id_o,
    output logic                         valid_o,
    input  logic                         ready_i
);
    import tdmr_pkg::*;
    import dp_pkg::*;

    // Three copies of every state element
    tdmr_state_e        state_v [3];
    tdmr_state_e        state_d [3];
    tdmr_state_e        state_q [3];
    logic [DATA_W-1:0]  data_d  [3];
    logic [DATA_W-1:0]  data_q  [3];
    logic [ID_SIZE-1:0] id_v    [3];
    logic [ID_SIZE-1:0] id_d    [3];
    logic [ID_SIZE-1:0] id_q    [3];
    logic [1:0]         state_vote;

    // Next state, computed separately for each copy
    for (genvar r = 0; r < 3; r++) begin : g_copy
        always_comb begin
            state_v[r] = state_q[r];
            data_d[r]  = data_q[r];
            id_v[r]    = id_q[r];
            case (state_q[r])
                STORE_AND_SEND: begin
                    // Idle state always takes a new word and keeps a copy of it
                    if (valid_i) begin
                        data_d[r] = data_i;
                        id_v[r]   = id_q[r] + 1'b1;
                        if (!ready_i) begin
                            state_v[r] = SEND;
                        end else if (enable_i) begin
                            state_v[r] = REPLICATE;
                        end
                    end
                end
                SEND: begin
                    if (ready_i) begin
                        if (enable_i) begin
                            state_v[r] = REPLICATE;
                        end else begin
                            state_v[r] = STORE_AND_SEND;
                        end
                    end
                end
                REPLICATE: begin
                    if (ready_i) begin
                        state_v[r] = STORE_AND_SEND;
                    end
                end
                default: begin
                    state_v[r] = STORE_AND_SEND;
                end
            endcase
        end
    end

    // Majority vote before the values are stored
    always_comb begin
        `VOTE3TO3ENUM(state_v, state_d, tdmr_state_e);
        `VOTE3TO3(id_v, id_d);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= '{default: STORE_AND_SEND};
            id_q    <= '{default: '0};
        end else begin
            state_q <= state_d;
            id_q    <= id_d;
        end
    end

    // Stored word, no reset needed
    always_ff @(posedge clk_i) begin
        data_q <= data_d;
    end

    // Handshake outputs follow the voted current state
    always_comb begin
        `VOTE3TO1(state_q, state_vote);
        valid_o = 1'b0;
        ready_o = 1'b0;
        case (state_vote)
            STORE_AND_SEND: begin
                valid_o = valid_i;
                ready_o = 1'b1;
            end
            SEND, REPLICATE: begin
                valid_o = 1'b1;
                ready_o = 1'b0;
            end
            default: begin
                valid_o = 1'b0;
                ready_o = 1'b0;
            end
        endcase
        // First copy passes straight through data_d, later copies come from the store
        `VOTE3TO1(data_d, data_o);
        `VOTE3TO1(id_v, id_o);
    end

endmodule

/* voters.svh */
`ifndef VOTERS_SVH
`define VOTERS_SVH

// Bitwise majority of three copies, written back into three voted copies
`define VOTE3TO3(in_a, out_a) \
    out_a[0] = (in_a[0] & in_a[1]) | (in_a[1] & in_a[2]) | (in_a[0] & in_a[2]); \
    out_a[1] = (in_a[0] & in_a[1]) | (in_a[1] & in_a[2]) | (in_a[0] & in_a[2]); \
    out_a[2] = (in_a[0] & in_a[1]) | (in_a[1] & in_a[2]) | (in_a[0] & in_a[2])

// Same vote for enum copies, the result is cast back to the enum type
`define VOTE3TO3ENUM(in_a, out_a, enum_t) \
    out_a[0] = enum_t'((in_a[0] & in_a[1]) | (in_a[1] & in_a[2]) | (in_a[0] & in_a[2])); \
    out_a[1] = enum_t'((in_a[0] & in_a[1]) | (in_a[1] & in_a[2]) | (in_a[0] & in_a[2])); \
    out_a[2] = enum_t'((in_a[0] & in_a[1]) | (in_a[1] & in_a[2]) | (in_a[0] & in_a[2]))

// Three copies down to one voted value
`define VOTE3TO1(in_a, out_s) \
    out_s = (in_a[0] & in_a[1]) | (in_a[1] & in_a[2]) | (in_a[0] & in_a[2])

`endif
